// ==== include/ex_consts.svh ====
// Fixed widths of the execute stage, shared by the package and the RTL
// Every value follows from the RV32 integer ISA
`ifndef EX_CONSTS_SVH
`define EX_CONSTS_SVH

////////////////////////////////////////////////////////////
// Datapath
////////////////////////////////////////////////////////////

// One machine word
`define EX_XLEN 32

// Register file address, covers integer and spare registers
`define EX_RADDR_W 6

// Shift amount taken from the low bits of operand b
`define EX_SHAMT_W 5

////////////////////////////////////////////////////////////
// Operator encodings
////////////////////////////////////////////////////////////

`define EX_ALU_OP_W 4
`define EX_MULT_OP_W 2

`endif

// ==== rtl/ex_pkg.sv ====
// Types shared by the execute stage and its testbench
// Compile before any module that names ex_pkg
`default_nettype none

package ex_pkg;

  `include "ex_consts.svh"

  // Data word and register file address
  typedef logic [`EX_XLEN-1:0]    word_t;
  typedef logic [`EX_RADDR_W-1:0] raddr_t;

  // ALU operators
  // Lower half is arithmetic and logic, upper half compares
  typedef enum logic [`EX_ALU_OP_W-1:0] {
    ALU_ADD  = 4'h0,
    ALU_SUB  = 4'h1,
    ALU_AND  = 4'h2,
    ALU_OR   = 4'h3,
    ALU_XOR  = 4'h4,
    ALU_SLL  = 4'h5,
    ALU_SRL  = 4'h6,
    ALU_SRA  = 4'h7,
    ALU_SLT  = 4'h8,
    ALU_SLTU = 4'h9,
    ALU_EQ   = 4'ha,
    ALU_NE   = 4'hb,
    ALU_LT   = 4'hc,
    ALU_GE   = 4'hd,
    ALU_LTU  = 4'he,
    ALU_GEU  = 4'hf
  } alu_op_e;

  // Multiplier operators, low word or one of the three high words
  typedef enum logic [`EX_MULT_OP_W-1:0] {
    MUL_L   = 2'd0,
    MUL_H   = 2'd1,
    MUL_HSU = 2'd2,
    MUL_HU  = 2'd3
  } mult_op_e;

  // Multiplier FSM
  typedef enum logic {
    MULT_IDLE = 1'b0,
    MULT_HIGH = 1'b1
  } mult_state_e;

endpackage

`default_nettype wire

// ==== rtl/ex_alu.sv ====
// Integer ALU of the execute stage
// Purely combinational, result and branch comparison from one operator
`default_nettype none

`include "ex_consts.svh"

module ex_alu (
  input  ex_pkg::alu_op_e alu_operator_i,
  input  ex_pkg::word_t   operand_a_i,
  input  ex_pkg::word_t   operand_b_i,
  output ex_pkg::word_t   result_o,
  output logic            cmp_result_o
);
  import ex_pkg::*;

  logic                     is_sub;
  word_t                    adder_b;
  word_t                    adder_sum;
  logic [`EX_SHAMT_W-1:0]   shamt;
  logic signed [`EX_XLEN:0] shr_in;
  logic signed [`EX_XLEN:0] shr_full;
  word_t                    shl_result;
  logic                     is_equal;
  logic                     less_signed;
  logic                     less_unsigned;

  ////////////////////////////////////////////////////////////
  // Adder
  ////////////////////////////////////////////////////////////

  // Subtract as a + ~b + 1 on the same adder
  assign is_sub    = (alu_operator_i == ALU_SUB);
  assign adder_b   = is_sub ? ~operand_b_i : operand_b_i;
  assign adder_sum = operand_a_i + adder_b + word_t'(is_sub);

  ////////////////////////////////////////////////////////////
  // Shifter
  ////////////////////////////////////////////////////////////

  assign shamt      = operand_b_i[`EX_SHAMT_W-1:0];
  assign shl_result = operand_a_i << shamt;

  // One extra top bit carries the sign for SRA, zero for SRL
  assign shr_in   = {(alu_operator_i == ALU_SRA) & operand_a_i[`EX_XLEN-1], operand_a_i};
  assign shr_full = shr_in >>> shamt;

  ////////////////////////////////////////////////////////////
  // Comparator
  ////////////////////////////////////////////////////////////

  assign is_equal      = (operand_a_i == operand_b_i);
  assign less_unsigned = (operand_a_i < operand_b_i);
  assign less_signed   = ($signed(operand_a_i) < $signed(operand_b_i));

  // Branch conditions, SLT and SLTU share the less-than paths
  always_comb begin
    case (alu_operator_i)
      ALU_EQ:            cmp_result_o = is_equal;
      ALU_NE:            cmp_result_o = ~is_equal;
      ALU_SLT, ALU_LT:   cmp_result_o = less_signed;
      ALU_GE:            cmp_result_o = ~less_signed;
      ALU_SLTU, ALU_LTU: cmp_result_o = less_unsigned;
      ALU_GEU:           cmp_result_o = ~less_unsigned;
      default:           cmp_result_o = 1'b0;
    endcase
  end

  // Result select
  always_comb begin
    case (alu_operator_i)
      ALU_ADD, ALU_SUB: result_o = adder_sum;
      ALU_AND:          result_o = operand_a_i & operand_b_i;
      ALU_OR:           result_o = operand_a_i | operand_b_i;
      ALU_XOR:          result_o = operand_a_i ^ operand_b_i;
      ALU_SLL:          result_o = shl_result;
      ALU_SRL, ALU_SRA: result_o = shr_full[`EX_XLEN-1:0];
      // Compares return the flag in bit 0
      default:          result_o = word_t'(cmp_result_o);
    endcase
  end

endmodule

`default_nettype wire

// ==== rtl/ex_mult.sv ====
// Integer multiplier of the execute stage
// MUL gives the low word in one cycle, MULH/MULHSU/MULHU take two cycles
`default_nettype none

`include "ex_consts.svh"

module ex_mult (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             enable_i,
  input  ex_pkg::mult_op_e operator_i,
  input  ex_pkg::word_t    op_a_i,
  input  ex_pkg::word_t    op_b_i,
  input  logic             ex_ready_i,
  output ex_pkg::word_t    result_o,
  output logic             multicycle_o,
  output logic             ready_o
);
  import ex_pkg::*;

  mult_state_e              state_q;
  mult_state_e              state_d;
  logic                     is_high;
  logic                     start_high;
  logic                     a_sign;
  logic                     b_sign;
  logic signed [17:0]       a_lo, a_hi;
  logic signed [17:0]       b_lo, b_hi;
  logic signed [35:0]       pp_ll_q, pp_lh_q, pp_hl_q, pp_hh_q;
  logic [2*`EX_XLEN-1:0]    prod_sum;
  word_t                    low_prod;

  // Widen a partial product to the full 64-bit product
  function automatic logic [2*`EX_XLEN-1:0] sext_pp(input logic signed [35:0] pp);
    sext_pp = {{(2*`EX_XLEN-36){pp[35]}}, pp};
  endfunction

  ////////////////////////////////////////////////////////////
  // Operand split
  ////////////////////////////////////////////////////////////

  assign is_high = (operator_i != MUL_L);

  // MULH signs both operands, MULHSU only a, MULHU none
  assign a_sign = op_a_i[`EX_XLEN-1] & ((operator_i == MUL_H) | (operator_i == MUL_HSU));
  assign b_sign = op_b_i[`EX_XLEN-1] & (operator_i == MUL_H);

  // Low halves unsigned, high halves carry the extension bit
  assign a_lo = $signed({2'b00, op_a_i[15:0]});
  assign a_hi = $signed({a_sign, a_sign, op_a_i[31:16]});
  assign b_lo = $signed({2'b00, op_b_i[15:0]});
  assign b_hi = $signed({b_sign, b_sign, op_b_i[31:16]});

  // Single-cycle low word
  assign low_prod = op_a_i * op_b_i;

  // First cycle of a high multiply
  assign start_high = (state_q == MULT_IDLE) & enable_i & is_high;

  // Partial products, loaded only when a high multiply starts
  always_ff @(posedge clk) begin
    if (start_high) begin
      pp_ll_q <= a_lo * b_lo;
      pp_lh_q <= a_lo * b_hi;
      pp_hl_q <= a_hi * b_lo;
      pp_hh_q <= a_hi * b_hi;
    end
  end

  // Second cycle sums the weighted partial products
  assign prod_sum = sext_pp(pp_ll_q)
                  + (sext_pp(pp_lh_q) << 16)
                  + (sext_pp(pp_hl_q) << 16)
                  + (sext_pp(pp_hh_q) << 32);

  ////////////////////////////////////////////////////////////
  // FSM
  ////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      // Skip the high cycle if the instruction leaves anyway (branch in EX)
      MULT_IDLE: if (start_high & ~ex_ready_i) state_d = MULT_HIGH;
      MULT_HIGH: if (ex_ready_i) state_d = MULT_IDLE;
      default:   state_d = MULT_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= MULT_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  assign multicycle_o = start_high;
  assign ready_o      = ~start_high;
  assign result_o     = (state_q == MULT_HIGH) ? prod_sum[2*`EX_XLEN-1:`EX_XLEN] : low_prod;

endmodule

`default_nettype wire

// ==== rtl/ex_writeback.sv ====
// Write-back side of the execute stage
// Forwarding mux, LSU port, EX/WB register and the ready/valid handshake
`default_nettype none

module ex_writeback (
  input  logic           clk,
  input  logic           rst_n,
  input  logic           alu_en_i,
  input  logic           mult_en_i,
  input  logic           csr_access_i,
  input  logic           lsu_en_i,
  input  logic           branch_in_ex_i,
  input  logic           regfile_alu_we_i,
  input  logic           regfile_we_i,
  input  logic           lsu_ready_ex_i,
  input  logic           lsu_err_i,
  input  logic           wb_ready_i,
  input  logic           mult_ready_i,
  input  ex_pkg::word_t  alu_result_i,
  input  ex_pkg::word_t  mult_result_i,
  input  ex_pkg::word_t  csr_rdata_i,
  input  ex_pkg::word_t  lsu_rdata_i,
  input  ex_pkg::raddr_t regfile_alu_waddr_i,
  input  ex_pkg::raddr_t regfile_waddr_i,
  output ex_pkg::word_t  regfile_alu_wdata_fw_o,
  output ex_pkg::word_t  regfile_wdata_wb_o,
  output ex_pkg::raddr_t regfile_alu_waddr_fw_o,
  output ex_pkg::raddr_t regfile_waddr_wb_o,
  output logic           regfile_alu_we_fw_o,
  output logic           regfile_we_wb_o,
  output logic           ex_ready_o,
  output logic           ex_valid_o
);

  logic units_ready;
  logic wb_load_we;

  ////////////////////////////////////////////////////////////
  // Forwarding port
  ////////////////////////////////////////////////////////////

  assign regfile_alu_we_fw_o    = regfile_alu_we_i;
  assign regfile_alu_waddr_fw_o = regfile_alu_waddr_i;

  // CSR wins over multiplier, multiplier over ALU
  always_comb begin
    if (csr_access_i) begin
      regfile_alu_wdata_fw_o = csr_rdata_i;
    end else if (mult_en_i) begin
      regfile_alu_wdata_fw_o = mult_result_i;
    end else if (alu_en_i) begin
      regfile_alu_wdata_fw_o = alu_result_i;
    end else begin
      regfile_alu_wdata_fw_o = '0;
    end
  end

  // Load data goes straight to the LSU write port
  assign regfile_wdata_wb_o = lsu_rdata_i;

  ////////////////////////////////////////////////////////////
  // Stall logic
  ////////////////////////////////////////////////////////////

  assign units_ready = mult_ready_i & lsu_ready_ex_i & wb_ready_i;

  // A branch retires in EX and never waits on WB
  assign ex_ready_o = units_ready | branch_in_ex_i;
  assign ex_valid_o = (alu_en_i | mult_en_i | csr_access_i | lsu_en_i) & units_ready;

  ////////////////////////////////////////////////////////////
  // EX/WB register
  ////////////////////////////////////////////////////////////

  // A faulting access must not write the register file
  assign wb_load_we = regfile_we_i & ~lsu_err_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      regfile_we_wb_o    <= 1'b0;
      regfile_waddr_wb_o <= '0;
    end else if (ex_valid_o) begin
      regfile_we_wb_o <= wb_load_we;
      if (wb_load_we) begin
        regfile_waddr_wb_o <= regfile_waddr_i;
      end
    end else if (wb_ready_i) begin
      // Nothing new arrives, so flush the slot
      regfile_we_wb_o <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/ex_stage.sv ====
// Execute stage top, integer part only
// Connects the ALU, the multiplier and the write-back control
`default_nettype none

module ex_stage (
  input  logic             clk,
  input  logic             rst_n,
  // ALU inputs from ID
  input  ex_pkg::alu_op_e  alu_operator_i,
  input  ex_pkg::word_t    alu_operand_a_i,
  input  ex_pkg::word_t    alu_operand_b_i,
  input  ex_pkg::word_t    alu_operand_c_i,
  input  logic             alu_en_i,
  // Multiplier inputs from ID
  input  ex_pkg::mult_op_e mult_operator_i,
  input  ex_pkg::word_t    mult_operand_a_i,
  input  ex_pkg::word_t    mult_operand_b_i,
  input  logic             mult_en_i,
  output logic             mult_multicycle_o,
  // LSU
  input  logic             lsu_en_i,
  input  ex_pkg::word_t    lsu_rdata_i,
  input  logic             lsu_ready_ex_i,
  input  logic             lsu_err_i,
  // Destinations and CSR
  input  logic             branch_in_ex_i,
  input  ex_pkg::raddr_t   regfile_alu_waddr_i,
  input  logic             regfile_alu_we_i,
  input  logic             regfile_we_i,
  input  ex_pkg::raddr_t   regfile_waddr_i,
  input  logic             csr_access_i,
  input  ex_pkg::word_t    csr_rdata_i,
  // LSU write port towards WB
  output ex_pkg::raddr_t   regfile_waddr_wb_o,
  output logic             regfile_we_wb_o,
  output ex_pkg::word_t    regfile_wdata_wb_o,
  // Forwarding port towards ID
  output ex_pkg::raddr_t   regfile_alu_waddr_fw_o,
  output logic             regfile_alu_we_fw_o,
  output ex_pkg::word_t    regfile_alu_wdata_fw_o,
  // Branch towards IF
  output ex_pkg::word_t    jump_target_o,
  output logic             branch_decision_o,
  // Handshake
  output logic             ex_ready_o,
  output logic             ex_valid_o,
  input  logic             wb_ready_i
);
  import ex_pkg::*;

  word_t alu_result;
  logic  alu_cmp_result;
  word_t mult_result;
  logic  mult_ready;

  // Branch decision and target come straight from EX
  assign branch_decision_o = alu_cmp_result;
  assign jump_target_o     = alu_operand_c_i;

  ////////////////////////////////////////////////////////////
  // Units
  ////////////////////////////////////////////////////////////

  ex_alu i_alu (
    .alu_operator_i ( alu_operator_i  ),
    .operand_a_i    ( alu_operand_a_i ),
    .operand_b_i    ( alu_operand_b_i ),
    .result_o       ( alu_result      ),
    .cmp_result_o   ( alu_cmp_result  )
  );

  ex_mult i_mult (
    .clk          ( clk               ),
    .rst_n        ( rst_n             ),
    .enable_i     ( mult_en_i         ),
    .operator_i   ( mult_operator_i   ),
    .op_a_i       ( mult_operand_a_i  ),
    .op_b_i       ( mult_operand_b_i  ),
    .ex_ready_i   ( ex_ready_o        ),
    .result_o     ( mult_result       ),
    .multicycle_o ( mult_multicycle_o ),
    .ready_o      ( mult_ready        )
  );

  ////////////////////////////////////////////////////////////
  // Write-back and pipeline control
  ////////////////////////////////////////////////////////////

  ex_writeback i_writeback (
    .clk                    ( clk                    ),
    .rst_n                  ( rst_n                  ),
    .alu_en_i               ( alu_en_i               ),
    .mult_en_i              ( mult_en_i              ),
    .csr_access_i           ( csr_access_i           ),
    .lsu_en_i               ( lsu_en_i               ),
    .branch_in_ex_i         ( branch_in_ex_i         ),
    .regfile_alu_we_i       ( regfile_alu_we_i       ),
    .regfile_we_i           ( regfile_we_i           ),
    .lsu_ready_ex_i         ( lsu_ready_ex_i         ),
    .lsu_err_i              ( lsu_err_i              ),
    .wb_ready_i             ( wb_ready_i             ),
    .mult_ready_i           ( mult_ready             ),
    .alu_result_i           ( alu_result             ),
    .mult_result_i          ( mult_result            ),
    .csr_rdata_i            ( csr_rdata_i            ),
    .lsu_rdata_i            ( lsu_rdata_i            ),
    .regfile_alu_waddr_i    ( regfile_alu_waddr_i    ),
    .regfile_waddr_i        ( regfile_waddr_i        ),
    .regfile_alu_wdata_fw_o ( regfile_alu_wdata_fw_o ),
    .regfile_wdata_wb_o     ( regfile_wdata_wb_o     ),
    .regfile_alu_waddr_fw_o ( regfile_alu_waddr_fw_o ),
    .regfile_waddr_wb_o     ( regfile_waddr_wb_o     ),
    .regfile_alu_we_fw_o    ( regfile_alu_we_fw_o    ),
    .regfile_we_wb_o        ( regfile_we_wb_o        ),
    .ex_ready_o             ( ex_ready_o             ),
    .ex_valid_o             ( ex_valid_o             )
  );

endmodule

`default_nettype wire

// ==== verif/ex_stage_sva.sv ====
// Bound checker for the execute stage, with its own reference model
// Attached to every ex_stage instance by the bind at the end of this file
`default_nettype none

`include "ex_consts.svh"

module ex_stage_sva (
  input logic             clk,
  input logic             rst_n,
  input ex_pkg::alu_op_e  alu_operator_i,
  input ex_pkg::word_t    alu_operand_a_i,
  input ex_pkg::word_t    alu_operand_b_i,
  input ex_pkg::word_t    alu_operand_c_i,
  input logic             alu_en_i,
  input ex_pkg::mult_op_e mult_operator_i,
  input ex_pkg::word_t    mult_operand_a_i,
  input ex_pkg::word_t    mult_operand_b_i,
  input logic             mult_en_i,
  input logic             mult_multicycle_o,
  input logic             lsu_en_i,
  input ex_pkg::word_t    lsu_rdata_i,
  input logic             lsu_ready_ex_i,
  input logic             lsu_err_i,
  input logic             branch_in_ex_i,
  input ex_pkg::raddr_t   regfile_alu_waddr_i,
  input logic             regfile_alu_we_i,
  input logic             regfile_we_i,
  input ex_pkg::raddr_t   regfile_waddr_i,
  input logic             csr_access_i,
  input ex_pkg::word_t    csr_rdata_i,
  input ex_pkg::raddr_t   regfile_waddr_wb_o,
  input logic             regfile_we_wb_o,
  input ex_pkg::word_t    regfile_wdata_wb_o,
  input ex_pkg::raddr_t   regfile_alu_waddr_fw_o,
  input logic             regfile_alu_we_fw_o,
  input ex_pkg::word_t    regfile_alu_wdata_fw_o,
  input ex_pkg::word_t    jump_target_o,
  input logic             branch_decision_o,
  input logic             ex_ready_o,
  input logic             ex_valid_o,
  input logic             wb_ready_i
);
  import ex_pkg::*;

  // Sticky, set by the first failing assertion
  logic   failed;
  // Multiply was already sitting in EX at the last edge
  logic   mult_held_q;
  logic   high_first;
  logic   path_clear;
  logic   exp_ready;
  logic   exp_valid;
  logic   exp_we_q;
  raddr_t exp_waddr_q;

  initial failed = 1'b0;

  ////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////

  // Branch and set-less-than conditions
  function automatic logic ref_cmp(alu_op_e op, word_t a, word_t b);
    case (op)
      ALU_EQ:            return a == b;
      ALU_NE:            return a != b;
      ALU_SLT, ALU_LT:   return $signed(a) < $signed(b);
      ALU_GE:            return $signed(a) >= $signed(b);
      ALU_SLTU, ALU_LTU: return a < b;
      ALU_GEU:           return a >= b;
      default:           return 1'b0;
    endcase
  endfunction

  // Result of the arithmetic, logic and SLT operators
  function automatic word_t ref_alu(alu_op_e op, word_t a, word_t b);
    logic [`EX_SHAMT_W-1:0] sh;
    sh = b[`EX_SHAMT_W-1:0];
    case (op)
      ALU_ADD: return a + b;
      ALU_SUB: return a - b;
      ALU_AND: return a & b;
      ALU_OR:  return a | b;
      ALU_XOR: return a ^ b;
      ALU_SLL: return a << sh;
      ALU_SRL: return a >> sh;
      ALU_SRA: return $signed(a) >>> sh;
      default: return {{(`EX_XLEN-1){1'b0}}, ref_cmp(op, a, b)};
    endcase
  endfunction

  // 64-bit product, operands extended per operator, then low or high word
  function automatic word_t ref_mul(mult_op_e op, word_t a, word_t b);
    logic                       sign_a;
    logic                       sign_b;
    logic signed [2*`EX_XLEN:0] wide_a;
    logic signed [2*`EX_XLEN:0] wide_b;
    logic signed [2*`EX_XLEN:0] prod;
    sign_a = (op == MUL_H) || (op == MUL_HSU);
    sign_b = (op == MUL_H);
    wide_a = {{(`EX_XLEN+1){a[`EX_XLEN-1] & sign_a}}, a};
    wide_b = {{(`EX_XLEN+1){b[`EX_XLEN-1] & sign_b}}, b};
    prod   = wide_a * wide_b;
    if (op == MUL_L) begin
      return prod[`EX_XLEN-1:0];
    end
    return prod[2*`EX_XLEN-1:`EX_XLEN];
  endfunction

  // Held state follows the ID handshake
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mult_held_q <= 1'b0;
      exp_we_q    <= 1'b0;
      exp_waddr_q <= '0;
    end else begin
      mult_held_q <= mult_en_i & ~ex_ready_o;
      exp_we_q    <= regfile_we_i & ~lsu_err_i;
      exp_waddr_q <= regfile_waddr_i;
    end
  end

  // First cycle of a high multiply is the only one with the multiplier busy
  assign high_first = mult_en_i && (mult_operator_i != MUL_L) && !mult_held_q;
  assign path_clear = !high_first && lsu_ready_ex_i && wb_ready_i;
  assign exp_ready  = path_clear || branch_in_ex_i;
  assign exp_valid  = (alu_en_i || mult_en_i || csr_access_i || lsu_en_i) && path_clear;

  ////////////////////////////////////////////////////////////
  // Forwarding port
  ////////////////////////////////////////////////////////////

  assert property (@(posedge clk) disable iff (!rst_n)
    {regfile_alu_we_fw_o, regfile_alu_waddr_fw_o} == {regfile_alu_we_i, regfile_alu_waddr_i})
  else begin
    failed = 1'b1;
    $error("error t=%0t regfile_alu_we_fw_o/waddr exp=%h act=%h", $time,
           {regfile_alu_we_i, regfile_alu_waddr_i}, {regfile_alu_we_fw_o, regfile_alu_waddr_fw_o});
  end

  assert property (@(posedge clk) disable iff (!rst_n)
    alu_en_i && !mult_en_i && !csr_access_i && alu_operator_i < ALU_EQ |->
      regfile_alu_wdata_fw_o == ref_alu(alu_operator_i, alu_operand_a_i, alu_operand_b_i))
  else begin
    failed = 1'b1;
    $error("error t=%0t regfile_alu_wdata_fw_o exp=%h act=%h", $time,
           ref_alu(alu_operator_i, alu_operand_a_i, alu_operand_b_i), regfile_alu_wdata_fw_o);
  end

  // CSR read data has the highest priority
  assert property (@(posedge clk) disable iff (!rst_n)
    csr_access_i |-> regfile_alu_wdata_fw_o == csr_rdata_i)
  else begin
    failed = 1'b1;
    $error("error t=%0t regfile_alu_wdata_fw_o exp=%h act=%h", $time,
           csr_rdata_i, regfile_alu_wdata_fw_o);
  end

  assert property (@(posedge clk) disable iff (!rst_n)
    !alu_en_i && !mult_en_i && !csr_access_i |-> regfile_alu_wdata_fw_o == '0)
  else begin
    failed = 1'b1;
    $error("error t=%0t regfile_alu_wdata_fw_o exp=0 act=%h", $time, regfile_alu_wdata_fw_o);
  end

  ////////////////////////////////////////////////////////////
  // Multiplier
  ////////////////////////////////////////////////////////////

  // Low word at once, high word from the second cycle on
  assert property (@(posedge clk) disable iff (!rst_n)
    mult_en_i && !csr_access_i && (mult_operator_i == MUL_L || mult_held_q) |->
      regfile_alu_wdata_fw_o == ref_mul(mult_operator_i, mult_operand_a_i, mult_operand_b_i))
  else begin
    failed = 1'b1;
    $error("error t=%0t regfile_alu_wdata_fw_o exp=%h act=%h", $time,
           ref_mul(mult_operator_i, mult_operand_a_i, mult_operand_b_i), regfile_alu_wdata_fw_o);
  end

  assert property (@(posedge clk) disable iff (!rst_n)
    high_first && !branch_in_ex_i |-> mult_multicycle_o && !ex_ready_o)
  else begin
    failed = 1'b1;
    $error("error t=%0t mult_multicycle_o/ex_ready_o exp=10 act=%b%b", $time,
           mult_multicycle_o, ex_ready_o);
  end

  ////////////////////////////////////////////////////////////
  // Branch
  ////////////////////////////////////////////////////////////

  assert property (@(posedge clk) disable iff (!rst_n)
    alu_operator_i >= ALU_SLT |->
      branch_decision_o == ref_cmp(alu_operator_i, alu_operand_a_i, alu_operand_b_i))
  else begin
    failed = 1'b1;
    $error("error t=%0t branch_decision_o exp=%b act=%b", $time,
           ref_cmp(alu_operator_i, alu_operand_a_i, alu_operand_b_i), branch_decision_o);
  end

  assert property (@(posedge clk) disable iff (!rst_n) jump_target_o == alu_operand_c_i)
  else begin
    failed = 1'b1;
    $error("error t=%0t jump_target_o exp=%h act=%h", $time, alu_operand_c_i, jump_target_o);
  end

  ////////////////////////////////////////////////////////////
  // EX/WB register and stall
  ////////////////////////////////////////////////////////////

  assert property (@(posedge clk) disable iff (!rst_n)
    ex_valid_o |=> regfile_we_wb_o == exp_we_q)
  else begin
    failed = 1'b1;
    $error("error t=%0t regfile_we_wb_o exp=%b act=%b", $time, exp_we_q, regfile_we_wb_o);
  end

  assert property (@(posedge clk) disable iff (!rst_n)
    ex_valid_o && regfile_we_i && !lsu_err_i |=> regfile_waddr_wb_o == exp_waddr_q)
  else begin
    failed = 1'b1;
    $error("error t=%0t regfile_waddr_wb_o exp=%h act=%h", $time,
           exp_waddr_q, regfile_waddr_wb_o);
  end

  // Empty slot is flushed when WB can take it
  assert property (@(posedge clk) disable iff (!rst_n)
    !ex_valid_o && wb_ready_i |=> !regfile_we_wb_o)
  else begin
    failed = 1'b1;
    $error("error t=%0t regfile_we_wb_o exp=0 act=%b", $time, regfile_we_wb_o);
  end

  assert property (@(posedge clk) disable iff (!rst_n) regfile_wdata_wb_o == lsu_rdata_i)
  else begin
    failed = 1'b1;
    $error("error t=%0t regfile_wdata_wb_o exp=%h act=%h", $time,
           lsu_rdata_i, regfile_wdata_wb_o);
  end

  assert property (@(posedge clk) disable iff (!rst_n) ex_ready_o == exp_ready)
  else begin
    failed = 1'b1;
    $error("error t=%0t ex_ready_o exp=%b act=%b", $time, exp_ready, ex_ready_o);
  end

  assert property (@(posedge clk) disable iff (!rst_n) ex_valid_o == exp_valid)
  else begin
    failed = 1'b1;
    $error("error t=%0t ex_valid_o exp=%b act=%b", $time, exp_valid, ex_valid_o);
  end

endmodule

bind ex_stage ex_stage_sva i_sva (.*);

`default_nettype wire

// ==== verif/tb_ex_stage.sv ====
// Random-stimulus testbench for the integer execute stage
// Drives ID, LSU and WB sides, the bound checker does the comparing
`default_nettype none

module tb_ex_stage;
  import ex_pkg::*;

  localparam int CLK_PERIOD   = 100;
  localparam int RESET_CYCLES = 3;
  localparam int N_INSTR      = 2000;
  // Four cycles per instruction, reset and a short tail
  localparam int TIMEOUT = (RESET_CYCLES + 4 * N_INSTR + 4) * CLK_PERIOD;

  logic        clk;
  logic        rst_n;
  alu_op_e     alu_operator_i;
  word_t       alu_operand_a_i;
  word_t       alu_operand_b_i;
  word_t       alu_operand_c_i;
  logic        alu_en_i;
  mult_op_e    mult_operator_i;
  word_t       mult_operand_a_i;
  word_t       mult_operand_b_i;
  logic        mult_en_i;
  logic        mult_multicycle_o;
  logic        lsu_en_i;
  word_t       lsu_rdata_i;
  logic        lsu_ready_ex_i;
  logic        lsu_err_i;
  logic        branch_in_ex_i;
  raddr_t      regfile_alu_waddr_i;
  logic        regfile_alu_we_i;
  logic        regfile_we_i;
  raddr_t      regfile_waddr_i;
  logic        csr_access_i;
  word_t       csr_rdata_i;
  raddr_t      regfile_waddr_wb_o;
  logic        regfile_we_wb_o;
  word_t       regfile_wdata_wb_o;
  raddr_t      regfile_alu_waddr_fw_o;
  logic        regfile_alu_we_fw_o;
  word_t       regfile_alu_wdata_fw_o;
  word_t       jump_target_o;
  logic        branch_decision_o;
  logic        ex_ready_o;
  logic        ex_valid_o;
  logic        wb_ready_i;
  // ex_ready_o as seen by the last rising edge
  logic        ready_seen;
  logic [31:0] lfsr_q;

  ex_stage i_ex_stage (.*);

  initial clk = 1'b0;
  always #(CLK_PERIOD / 2) clk = ~clk;

  always @(posedge clk) ready_seen <= ex_ready_o;

  // Galois LFSR, x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    lfsr_next = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // Shift in n random bits, one LFSR step each
  task automatic get_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      v = {v[30:0], lfsr_q[0]};
    end
  endtask

  // High one time in eight
  task automatic get_rare(output logic b);
    logic [31:0] v;
    get_bits(3, v);
    b = (v[2:0] == 3'd0);
  endtask

  // WB and LSU handshakes, mostly ready
  task automatic drive_handshake();
    logic bit_v;
    get_rare(bit_v);
    wb_ready_i = ~bit_v;
    get_rare(bit_v);
    lsu_ready_ex_i = ~bit_v;
    get_rare(lsu_err_i);
    get_rare(branch_in_ex_i);
  endtask

  task automatic drive_instr();
    logic [31:0] v;
    logic        extra;
    get_bits(2, v);
    alu_en_i     = (v[1:0] == 2'd0);
    mult_en_i    = (v[1:0] == 2'd1);
    csr_access_i = (v[1:0] == 2'd2);
    lsu_en_i     = (v[1:0] == 2'd3);
    // Sometimes a second unit, so the port priority gets exercised
    get_rare(extra);
    alu_en_i = alu_en_i | extra;
    get_rare(extra);
    mult_en_i = mult_en_i | extra;
    get_rare(extra);
    csr_access_i = csr_access_i | extra;
    get_bits(4, v);
    alu_operator_i = alu_op_e'(v[3:0]);
    get_bits(32, v);
    alu_operand_a_i = v;
    get_bits(32, v);
    alu_operand_b_i = v;
    // Equal operands now and then for EQ, NE and GE
    get_rare(extra);
    if (extra) begin
      alu_operand_b_i = alu_operand_a_i;
    end
    get_bits(32, v);
    alu_operand_c_i = v;
    get_bits(2, v);
    mult_operator_i = mult_op_e'(v[1:0]);
    get_bits(32, v);
    mult_operand_a_i = v;
    get_bits(32, v);
    mult_operand_b_i = v;
    get_bits(32, v);
    csr_rdata_i = v;
    get_bits(32, v);
    lsu_rdata_i = v;
    get_bits(6, v);
    regfile_alu_waddr_i = v[5:0];
    get_bits(6, v);
    regfile_waddr_i = v[5:0];
    get_bits(2, v);
    regfile_alu_we_i = v[0];
    regfile_we_i     = v[1];
  endtask

  initial begin
    lfsr_q              = 32'h070e_be04;
    rst_n               = 1'b0;
    alu_operator_i      = ALU_ADD;
    alu_operand_a_i     = '0;
    alu_operand_b_i     = '0;
    alu_operand_c_i     = '0;
    alu_en_i            = 1'b0;
    mult_operator_i     = MUL_L;
    mult_operand_a_i    = '0;
    mult_operand_b_i    = '0;
    mult_en_i           = 1'b0;
    lsu_en_i            = 1'b0;
    lsu_rdata_i         = '0;
    lsu_ready_ex_i      = 1'b1;
    lsu_err_i           = 1'b0;
    branch_in_ex_i      = 1'b0;
    regfile_alu_waddr_i = '0;
    regfile_alu_we_i    = 1'b0;
    regfile_we_i        = 1'b0;
    regfile_waddr_i     = '0;
    csr_access_i        = 1'b0;
    csr_rdata_i         = '0;
    wb_ready_i          = 1'b1;
    repeat (RESET_CYCLES) @(negedge clk);
    rst_n = 1'b1;
    for (int n = 0; n < N_INSTR; n++) begin
      drive_instr();
      drive_handshake();
      // Hold the instruction until an edge with ex_ready_o takes it
      do begin
        @(negedge clk);
        if (!ready_seen) begin
          drive_handshake();
        end
      end while (!ready_seen);
    end
    // Let the last registered checks complete
    repeat (2) @(negedge clk);
    if (i_ex_stage.i_sva.failed) begin
      $display("TEST FAILED");
      $fatal(1, "an assertion in the execute stage failed");
    end else begin
      $display("TEST PASSED");
      $finish;
    end
  end

  // Stop at the first assertion failure
  initial begin
    wait (i_ex_stage.i_sva.failed === 1'b1);
    $display("TEST FAILED");
    $fatal(1, "an assertion in the execute stage failed");
  end

  initial begin
    #(TIMEOUT);
    $display("TEST FAILED");
    $fatal(1, "watchdog expired before all instructions were taken");
  end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+include
rtl/ex_pkg.sv
rtl/ex_alu.sv
rtl/ex_mult.sv
rtl/ex_writeback.sv
rtl/ex_stage.sv
verif/ex_stage_sva.sv
verif/tb_ex_stage.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the execute stage testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --assert --top-module tb_ex_stage -f src.f --Mdir obj_dir -o sim_ex_stage
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_ex_stage +verilator+error+limit+100 2>&1 | tee "$log"
sim_status=${PIPESTATUS[0]}

if grep -q "TEST FAILED" "$log"; then
  echo "Simulation reported a failure, see $log"
  exit 1
fi

if [ "$sim_status" -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

exit 0
